// File: hdl/bp_pkg.sv
package bp_pkg;

        // Instruction word or byte address.
        typedef logic [31:0] word_t;

        // Condition flags, N Z C V from bit 3 down to bit 0.
        typedef logic [3:0] flags_t;

        // Two-bit saturating counter value.
        typedef logic [1:0] bstate_t;

        // ARM condition field.
        typedef logic [3:0] cond_t;

        localparam int FLAG_N = 3;
        localparam int FLAG_Z = 2;
        localparam int FLAG_C = 1;
        localparam int FLAG_V = 0;

        // Counter states, strongly not taken up to strongly taken.
        localparam bstate_t BSTATE_SNT = 2'd0;
        localparam bstate_t BSTATE_WNT = 2'd1;
        localparam bstate_t BSTATE_WT  = 2'd2;
        localparam bstate_t BSTATE_ST  = 2'd3;

        localparam cond_t COND_EQ = 4'h0;
        localparam cond_t COND_NE = 4'h1;
        localparam cond_t COND_CS = 4'h2;
        localparam cond_t COND_CC = 4'h3;
        localparam cond_t COND_MI = 4'h4;
        localparam cond_t COND_PL = 4'h5;
        localparam cond_t COND_VS = 4'h6;
        localparam cond_t COND_VC = 4'h7;
        localparam cond_t COND_HI = 4'h8;
        localparam cond_t COND_LS = 4'h9;
        localparam cond_t COND_GE = 4'ha;
        localparam cond_t COND_LT = 4'hb;
        localparam cond_t COND_GT = 4'hc;
        localparam cond_t COND_LE = 4'hd;
        localparam cond_t COND_AL = 4'he;
        localparam cond_t COND_NV = 4'hf;

        typedef struct packed {
                logic  valid;
                logic  abort;
                word_t instr;
                word_t pc_plus_8;
        } fetch_t;

        typedef struct packed {
                logic  valid;
                word_t pc;
        } redirect_t;

endpackage

// File: hdl/branch_predict.sv
`timescale 1ns/1ps

module branch_predict #(
        parameter int INDEX_BITS = 9
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_stall,
        input  bp_pkg::fetch_t        i_fetch,
        input  logic                  i_flush_decode,
        input  logic                  i_flush_exec,
        input  logic                  i_update_valid,
        input  logic [INDEX_BITS-1:0] i_update_index,
        input  logic                  i_update_taken,
        output bp_pkg::fetch_t        o_fetch,
        output bp_pkg::bstate_t       o_bstate,
        output logic                  o_ready
);

        import bp_pkg::*;

        localparam int ENTRIES = 2 ** INDEX_BITS;

        typedef struct packed {
                logic                  valid;
                logic [INDEX_BITS-1:0] index;
                logic                  taken;
        } update_t;

        bstate_t               table_mem [ENTRIES];
        update_t               upd;
        word_t                 fetch_pc;
        logic [INDEX_BITS-1:0] rd_index;
        logic                  sweep_busy;
        logic [INDEX_BITS-1:0] sweep_idx;

        // Saturating up/down step of one counter.
        function automatic bstate_t train(bstate_t s, logic taken);
                bstate_t n;
                n = s;
                if (taken && s != BSTATE_ST)
                        n = s + 2'd1;
                else if (!taken && s != BSTATE_SNT)
                        n = s - 2'd1;
                return n;
        endfunction

        assign upd      = '{valid: i_update_valid, index: i_update_index, taken: i_update_taken};
        assign fetch_pc = i_fetch.pc_plus_8 - 32'd8;
        assign rd_index = fetch_pc[INDEX_BITS+1:2];
        assign o_ready  = ~sweep_busy;

        // Clear sweep, one entry per cycle after reset.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        sweep_busy <= 1'b1;
                        sweep_idx  <= '0;
                end
                else if (sweep_busy)
                begin
                        sweep_idx <= sweep_idx + 1'b1;
                        if (sweep_idx == '1)
                                sweep_busy <= 1'b0;
                end
        end

        // Table write, the sweep takes the port while it runs.
        always_ff @(posedge i_clk)
        begin
                if (sweep_busy)
                        table_mem[sweep_idx] <= BSTATE_SNT;
                else if (upd.valid)
                        table_mem[upd.index] <= train(table_mem[upd.index], upd.taken);
        end

        // Stage register. Flushes win over the stall.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || sweep_busy || i_flush_exec || i_flush_decode)
                begin
                        o_fetch <= '{valid: 1'b0, abort: 1'b0, instr: '0, pc_plus_8: 32'd8};
                end
                else if (!i_stall)
                begin
                        o_fetch <= i_fetch;
                end
        end

        // Counter read. Same-cycle update returns the old value.
        always_ff @(posedge i_clk)
        begin
                if (!i_stall)
                        o_bstate <= table_mem[rd_index];
        end

endmodule

// File: hdl/branch_decode.sv
`timescale 1ns/1ps

module branch_decode #(
        parameter int INDEX_BITS = 9
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_stall,
        input  logic                  i_flush_exec,
        input  bp_pkg::fetch_t        i_fetch,
        input  bp_pkg::bstate_t       i_bstate,
        output logic                  o_dec_valid,
        output logic                  o_dec_is_branch,
        output logic                  o_dec_link,
        output bp_pkg::cond_t         o_dec_cond,
        output logic                  o_dec_pred_taken,
        output logic [INDEX_BITS-1:0] o_dec_index,
        output bp_pkg::word_t         o_dec_target,
        output bp_pkg::word_t         o_dec_fall_through,
        output logic                  o_flush,
        output bp_pkg::redirect_t     o_redirect
);

        import bp_pkg::*;

        typedef struct packed {
                logic                  valid;
                logic                  is_branch;
                logic                  link;
                cond_t                 cond;
                logic                  pred_taken;
                logic [INDEX_BITS-1:0] index;
                word_t                 target;
                word_t                 fall_through;
        } dec_t;

        dec_t  dec_d;
        dec_t  dec_q;
        word_t fetch_pc;
        word_t offset;

        assign fetch_pc = i_fetch.pc_plus_8 - 32'd8;

        // Signed 24-bit word offset.
        assign offset = {{6{i_fetch.instr[23]}}, i_fetch.instr[23:0], 2'b00};

        always_comb
        begin
                dec_d.valid        = i_fetch.valid;
                dec_d.is_branch    = i_fetch.valid && !i_fetch.abort &&
                                     i_fetch.instr[27:25] == 3'b101 &&
                                     i_fetch.instr[31:28] != COND_NV;
                dec_d.link         = i_fetch.instr[24];
                dec_d.cond         = i_fetch.instr[31:28];
                dec_d.pred_taken   = dec_d.is_branch && i_bstate >= BSTATE_WT;
                dec_d.index        = fetch_pc[INDEX_BITS+1:2];
                dec_d.target       = i_fetch.pc_plus_8 + offset;
                dec_d.fall_through = i_fetch.pc_plus_8 - 32'd4;
        end

        // A predicted redirect also drops the word coming in behind it.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_flush_exec || o_flush)
                        dec_q.valid <= 1'b0;
                else if (!i_stall)
                        dec_q <= dec_d;
        end

        assign o_flush    = dec_q.valid && dec_q.pred_taken && !i_stall;
        assign o_redirect = '{valid: o_flush, pc: dec_q.target};

        assign o_dec_valid        = dec_q.valid;
        assign o_dec_is_branch    = dec_q.is_branch;
        assign o_dec_link         = dec_q.link;
        assign o_dec_cond         = dec_q.cond;
        assign o_dec_pred_taken   = dec_q.pred_taken;
        assign o_dec_index        = dec_q.index;
        assign o_dec_target       = dec_q.target;
        assign o_dec_fall_through = dec_q.fall_through;

endmodule

// File: hdl/branch_execute.sv
`timescale 1ns/1ps

module branch_execute #(
        parameter int INDEX_BITS = 9
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_stall,
        input  logic                  i_dec_valid,
        input  logic                  i_dec_is_branch,
        input  logic                  i_dec_link,
        input  bp_pkg::cond_t         i_dec_cond,
        input  logic                  i_dec_pred_taken,
        input  logic [INDEX_BITS-1:0] i_dec_index,
        input  bp_pkg::word_t         i_dec_target,
        input  bp_pkg::word_t         i_dec_fall_through,
        input  bp_pkg::flags_t        i_flags,
        output logic                  o_update_valid,
        output logic [INDEX_BITS-1:0] o_update_index,
        output logic                  o_update_taken,
        output logic                  o_flush,
        output bp_pkg::redirect_t     o_redirect,
        output logic                  o_resolved
);

        import bp_pkg::*;

        typedef struct packed {
                logic                  valid;
                logic                  is_branch;
                logic                  link;
                cond_t                 cond;
                logic                  pred_taken;
                logic [INDEX_BITS-1:0] index;
                word_t                 target;
                word_t                 fall_through;
        } dec_t;

        typedef struct packed {
                logic                  valid;
                logic [INDEX_BITS-1:0] index;
                logic                  taken;
        } update_t;

        dec_t    dec;
        update_t upd;
        logic    resolve;
        logic    taken;
        logic    mispredict;

        // ARM condition table.
        function automatic logic cond_pass(cond_t c, flags_t f);
                logic n;
                logic z;
                logic cy;
                logic v;
                n  = f[FLAG_N];
                z  = f[FLAG_Z];
                cy = f[FLAG_C];
                v  = f[FLAG_V];
                case (c)
                COND_EQ: return z;
                COND_NE: return !z;
                COND_CS: return cy;
                COND_CC: return !cy;
                COND_MI: return n;
                COND_PL: return !n;
                COND_VS: return v;
                COND_VC: return !v;
                COND_HI: return cy && !z;
                COND_LS: return !cy || z;
                COND_GE: return n == v;
                COND_LT: return n != v;
                COND_GT: return !z && (n == v);
                COND_LE: return z || (n != v);
                COND_AL: return 1'b1;
                default: return 1'b0;
                endcase
        endfunction

        assign dec = '{valid: i_dec_valid, is_branch: i_dec_is_branch, link: i_dec_link,
                       cond: i_dec_cond, pred_taken: i_dec_pred_taken, index: i_dec_index,
                       target: i_dec_target, fall_through: i_dec_fall_through};

        // Stall holds execute idle.
        assign resolve    = dec.valid && dec.is_branch && !i_stall;
        assign taken      = cond_pass(dec.cond, i_flags);
        assign mispredict = resolve && (taken != dec.pred_taken);

        assign upd = '{valid: resolve, index: dec.index, taken: taken};

        assign o_update_valid = upd.valid;
        assign o_update_index = upd.index;
        assign o_update_taken = upd.taken;
        assign o_resolved     = resolve;
        assign o_flush        = mispredict;
        assign o_redirect     = '{valid: mispredict, pc: taken ? dec.target : dec.fall_through};

endmodule

// File: hdl/branch_result.sv
`timescale 1ns/1ps

module branch_result #(
        parameter int COUNT_BITS = 16
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  bp_pkg::redirect_t     i_decode_redirect,
        input  bp_pkg::redirect_t     i_exec_redirect,
        input  logic                  i_resolved,
        output bp_pkg::redirect_t     o_redirect,
        output logic [COUNT_BITS-1:0] o_branch_count,
        output logic [COUNT_BITS-1:0] o_mispredict_count
);

        import bp_pkg::*;

        redirect_t sel;

        // Mispredict correction belongs to the older instruction.
        assign sel = i_exec_redirect.valid ? i_exec_redirect : i_decode_redirect;

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                        o_redirect <= '0;
                else
                        o_redirect <= sel;
        end

        // Statistics, both wrap.
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        o_branch_count     <= '0;
                        o_mispredict_count <= '0;
                end
                else
                begin
                        if (i_resolved)
                                o_branch_count <= o_branch_count + 1'b1;
                        if (i_exec_redirect.valid)
                                o_mispredict_count <= o_mispredict_count + 1'b1;
                end
        end

endmodule

// File: hdl/branch_unit_top.sv
`timescale 1ns/1ps

module branch_unit_top #(
        parameter int INDEX_BITS = 9,
        parameter int COUNT_BITS = 16
) (
        input  logic                  i_clk,
        input  logic                  i_reset,
        input  logic                  i_stall,
        input  bp_pkg::fetch_t        i_fetch,
        input  bp_pkg::flags_t        i_flags,
        output logic                  o_ready,
        output bp_pkg::redirect_t     o_redirect,
        output logic [COUNT_BITS-1:0] o_branch_count,
        output logic [COUNT_BITS-1:0] o_mispredict_count
);

        import bp_pkg::*;

        fetch_t                pred_fetch;
        bstate_t               pred_bstate;
        logic                  dec_valid;
        logic                  dec_is_branch;
        logic                  dec_link;
        cond_t                 dec_cond;
        logic                  dec_pred_taken;
        logic [INDEX_BITS-1:0] dec_index;
        word_t                 dec_target;
        word_t                 dec_fall_through;
        logic                  flush_decode;
        logic                  flush_exec;
        logic                  update_valid;
        logic [INDEX_BITS-1:0] update_index;
        logic                  update_taken;
        redirect_t             decode_redirect;
        redirect_t             exec_redirect;
        logic                  resolved;

        branch_predict #(.INDEX_BITS(INDEX_BITS)) u_predict (
                .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall), .i_fetch(i_fetch),
                .i_flush_decode(flush_decode), .i_flush_exec(flush_exec),
                .i_update_valid(update_valid), .i_update_index(update_index),
                .i_update_taken(update_taken), .o_fetch(pred_fetch),
                .o_bstate(pred_bstate), .o_ready(o_ready)
        );

        branch_decode #(.INDEX_BITS(INDEX_BITS)) u_decode (
                .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall),
                .i_flush_exec(flush_exec), .i_fetch(pred_fetch), .i_bstate(pred_bstate),
                .o_dec_valid(dec_valid), .o_dec_is_branch(dec_is_branch),
                .o_dec_link(dec_link), .o_dec_cond(dec_cond),
                .o_dec_pred_taken(dec_pred_taken), .o_dec_index(dec_index),
                .o_dec_target(dec_target), .o_dec_fall_through(dec_fall_through),
                .o_flush(flush_decode), .o_redirect(decode_redirect)
        );

        branch_execute #(.INDEX_BITS(INDEX_BITS)) u_execute (
                .i_clk(i_clk), .i_reset(i_reset), .i_stall(i_stall),
                .i_dec_valid(dec_valid), .i_dec_is_branch(dec_is_branch),
                .i_dec_link(dec_link), .i_dec_cond(dec_cond),
                .i_dec_pred_taken(dec_pred_taken), .i_dec_index(dec_index),
                .i_dec_target(dec_target), .i_dec_fall_through(dec_fall_through),
                .i_flags(i_flags), .o_update_valid(update_valid),
                .o_update_index(update_index), .o_update_taken(update_taken),
                .o_flush(flush_exec), .o_redirect(exec_redirect), .o_resolved(resolved)
        );

        branch_result #(.COUNT_BITS(COUNT_BITS)) u_result (
                .i_clk(i_clk), .i_reset(i_reset), .i_decode_redirect(decode_redirect),
                .i_exec_redirect(exec_redirect), .i_resolved(resolved),
                .o_redirect(o_redirect), .o_branch_count(o_branch_count),
                .o_mispredict_count(o_mispredict_count)
        );

endmodule

// File: tests/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit;

        import bp_pkg::*;

        localparam int INDEX_BITS       = 9;
        localparam int COUNT_BITS       = 16;
        localparam int TABLE_SIZE       = 2 ** INDEX_BITS;
        localparam int READY_TIMEOUT    = 2 * TABLE_SIZE + 16;
        localparam int REDIRECT_TIMEOUT = 8;
        localparam int STALL_CYCLES     = 4;

        logic                  clk = 1'b0;
        logic                  reset;
        logic                  stall;
        fetch_t                fetch;
        flags_t                flags;
        logic                  ready;
        redirect_t             redirect;
        logic [COUNT_BITS-1:0] branch_count;
        logic [COUNT_BITS-1:0] mispredict_count;

        // Reference counter table and expected statistics.
        bstate_t               model [TABLE_SIZE];
        logic [COUNT_BITS-1:0] exp_branches;
        logic [COUNT_BITS-1:0] exp_mispredicts;
        int                    errors;
        int                    checks;

        branch_unit_top #(.INDEX_BITS(INDEX_BITS), .COUNT_BITS(COUNT_BITS)) u_dut (
                .i_clk(clk), .i_reset(reset), .i_stall(stall), .i_fetch(fetch),
                .i_flags(flags), .o_ready(ready), .o_redirect(redirect),
                .o_branch_count(branch_count), .o_mispredict_count(mispredict_count)
        );

        always #50 clk = ~clk;

        task automatic check_value(input string name, input word_t expected,
                                   input word_t actual);
                checks++;
                if (expected !== actual)
                begin
                        errors++;
                        $display("Error at %0t: %s expected %h, actual %h",
                                 $time, name, expected, actual);
                end
        endtask

        task automatic verify_statistics();
                check_value("o_branch_count", 32'(exp_branches), 32'(branch_count));
                check_value("o_mispredict_count", 32'(exp_mispredicts), 32'(mispredict_count));
        endtask

        function automatic word_t random_pc();
                return $urandom & 32'h000f_fffc;
        endfunction

        function automatic logic [23:0] draw_offset();
                word_t r;
                r = $urandom;
                return r[23:0];
        endfunction

        // ARM B encoding, link bit clear.
        function automatic word_t encode_b(input cond_t cond, input logic [23:0] off);
                return {cond, 3'b101, 1'b0, off};
        endfunction

        function automatic word_t target_of(input word_t pc, input logic [23:0] off);
                return pc + 32'd8 + {{6{off[23]}}, off, 2'b00};
        endfunction

        // Chosen NZCV flags and whether the condition passes on them.
        function automatic logic [4:0] flags_for_cond(input cond_t cond);
                case (cond)
                COND_EQ: return {4'b0100, 1'b1};
                COND_NE: return {4'b0100, 1'b0};
                COND_CS: return {4'b0010, 1'b1};
                COND_CC: return {4'b0010, 1'b0};
                COND_MI: return {4'b1000, 1'b1};
                COND_PL: return {4'b1000, 1'b0};
                COND_VS: return {4'b0001, 1'b1};
                COND_VC: return {4'b0001, 1'b0};
                COND_HI: return {4'b0010, 1'b1};
                COND_LS: return {4'b0110, 1'b1};   // Z set is enough
                COND_GE: return {4'b1001, 1'b1};
                COND_LT: return {4'b1000, 1'b1};
                COND_GT: return {4'b0100, 1'b0};
                COND_LE: return {4'b0100, 1'b1};
                default: return {4'b0000, 1'b1};
                endcase
        endfunction

        task automatic idle_fetch();
                fetch = '{valid: 1'b0, abort: 1'b0, instr: '0, pc_plus_8: 32'd8};
        endtask

        // One fetch word for one cycle, then bubbles.
        task automatic send_word(input word_t pc, input word_t instr, input logic abort);
                fetch = '{valid: 1'b1, abort: abort, instr: instr, pc_plus_8: pc + 32'd8};
                @(negedge clk);
                idle_fetch();
        endtask

        task automatic wait_redirect(input logic exp_valid, input word_t exp_pc);
                int   cycles;
                logic seen;
                cycles = 0;
                seen   = 1'b0;
                while (!seen && cycles < REDIRECT_TIMEOUT)
                begin
                        @(negedge clk);
                        cycles++;
                        seen = redirect.valid;
                end
                if (exp_valid && !seen)
                begin
                        errors++;
                        $display("Timeout: no redirect to %h after %0d cycles", exp_pc, cycles);
                end
                else
                        check_value("o_redirect.valid", 32'(exp_valid), 32'(seen));
                if (seen && exp_valid)
                        check_value("o_redirect.pc", exp_pc, redirect.pc);
                if (seen)
                begin
                        // The redirect is a single-cycle pulse.
                        @(negedge clk);
                        check_value("o_redirect.valid after pulse", 32'd0, 32'(redirect.valid));
                end
        endtask

        // Saturating training of the model and expected statistics.
        task automatic record_outcome(input logic [INDEX_BITS-1:0] idx, input logic pred,
                                      input logic taken);
                exp_branches++;
                if (pred != taken)
                        exp_mispredicts++;
                if (taken && model[idx] != BSTATE_ST)
                        model[idx] = model[idx] + 2'd1;
                else if (!taken && model[idx] != BSTATE_SNT)
                        model[idx] = model[idx] - 2'd1;
                verify_statistics();
        endtask

        task automatic issue_branch(input word_t pc, input cond_t cond, input flags_t f,
                                    input logic [23:0] off, input logic taken);
                logic [INDEX_BITS-1:0] idx;
                logic                  pred;
                word_t                 target;
                idx    = pc[INDEX_BITS+1:2];
                pred   = model[idx] >= BSTATE_WT;
                target = target_of(pc, off);
                flags  = f;
                send_word(pc, encode_b(cond, off), 1'b0);
                wait_redirect(pred || taken, taken ? target : pc + 32'd4);
                record_outcome(idx, pred, taken);
        endtask

        // A word that must never resolve, train or redirect.
        task automatic send_non_branch(input word_t pc, input word_t instr, input logic abort);
                send_word(pc, instr, abort);
                wait_redirect(1'b0, '0);
                verify_statistics();
        endtask

        task automatic cold_branch_not_taken();
                issue_branch(random_pc(), COND_EQ, 4'b0000, draw_offset(), 1'b0);
        endtask

        task automatic train_then_untrain();
                word_t       pc;
                logic [23:0] off;
                pc  = random_pc();
                off = draw_offset();
                // Two mispredicts reach WT, then decode predicts, then ST holds.
                repeat (4)
                        issue_branch(pc, COND_AL, 4'b0000, off, 1'b1);
                // Failing EQ goes back to pc + 4 and the counter drops to WT.
                issue_branch(pc, COND_EQ, 4'b0000, off, 1'b0);
        endtask

        task automatic condition_code_sweep();
                logic [4:0] vec;
                for (int c = 0; c < 16; c++)
                begin
                        vec = flags_for_cond(cond_t'(c));
                        if (cond_t'(c) == COND_NV)
                                send_non_branch(random_pc(), encode_b(COND_NV, draw_offset()), 1'b0);
                        else
                                issue_branch(random_pc(), cond_t'(c), vec[4:1], draw_offset(), vec[0]);
                end
        endtask

        task automatic flush_and_priority();
                word_t                 pc_a;
                word_t                 pc_b;
                logic [23:0]           off_a;
                logic [23:0]           off_b;
                logic [INDEX_BITS-1:0] idx_a;
                logic                  taken_a;
                int                    guard;
                pc_a  = random_pc();
                pc_b  = pc_a + 32'd4;
                off_a = draw_offset();
                off_b = draw_offset();
                idx_a = pc_a[INDEX_BITS+1:2];
                guard = 0;
                // Younger branch counter to exactly WT.
                while (model[pc_b[INDEX_BITS+1:2]] != BSTATE_WT && guard < 4)
                begin
                        if (model[pc_b[INDEX_BITS+1:2]] < BSTATE_WT)
                                issue_branch(pc_b, COND_AL, 4'b0000, off_b, 1'b1);
                        else
                                issue_branch(pc_b, COND_EQ, 4'b0000, off_b, 1'b0);
                        guard++;
                end
                taken_a = model[idx_a] < BSTATE_WT;
                flags   = 4'b0000;
                send_word(pc_a, encode_b(taken_a ? COND_AL : COND_EQ, off_a), 1'b0);
                // EQ fails here, so any training of this one would drop it to WNT.
                send_word(pc_b, encode_b(COND_EQ, off_b), 1'b0);
                wait_redirect(1'b1, taken_a ? target_of(pc_a, off_a) : pc_a + 32'd4);
                record_outcome(idx_a, !taken_a, taken_a);
                // Still predicted taken when the flushed branch left the table alone.
                issue_branch(pc_b, COND_AL, 4'b0000, off_b, 1'b1);
        endtask

        task automatic stall_and_abort();
                word_t                 pc;
                logic [23:0]           off;
                logic [INDEX_BITS-1:0] idx;
                logic                  pred;
                pc    = random_pc();
                off   = draw_offset();
                idx   = pc[INDEX_BITS+1:2];
                pred  = model[idx] >= BSTATE_WT;
                flags = 4'b0000;
                send_word(pc, encode_b(COND_AL, off), 1'b0);
                stall = 1'b1;
                repeat (STALL_CYCLES)
                begin
                        @(negedge clk);
                        check_value("o_redirect.valid in stall", 32'd0, 32'(redirect.valid));
                end
                verify_statistics();
                stall = 1'b0;
                wait_redirect(1'b1, target_of(pc, off));
                record_outcome(idx, pred, 1'b1);
                // Aborted word that decodes as an AL branch.
                send_non_branch(random_pc(), encode_b(COND_AL, draw_offset()), 1'b1);
        endtask

        initial
        begin
                int cycles;
                errors          = 0;
                checks          = 0;
                exp_branches    = '0;
                exp_mispredicts = '0;
                void'($urandom(32'h1e76_5b6c));
                reset = 1'b1;
                stall = 1'b0;
                flags = 4'b0000;
                idle_fetch();
                for (int i = 0; i < TABLE_SIZE; i++)
                        model[i] = BSTATE_SNT;
                repeat (5) @(negedge clk);
                reset = 1'b0;
                // Table clear sweep.
                cycles = 0;
                while (ready !== 1'b1 && cycles < READY_TIMEOUT)
                begin
                        @(negedge clk);
                        cycles++;
                end
                if (ready !== 1'b1)
                begin
                        errors++;
                        $display("Timeout: o_ready still low %0d cycles after reset", cycles);
                end
                verify_statistics();
                check_value("o_redirect.valid after reset", 32'd0, 32'(redirect.valid));
                cold_branch_not_taken();
                train_then_untrain();
                condition_code_sweep();
                flush_and_priority();
                stall_and_abort();
                $display("Checks: %0d, errors: %0d", checks, errors);
                if (errors == 0)
                        $display("Done: no errors");
                else
                        $display("Done: errors found");
                $finish;
        end

endmodule

// File: branch_unit_top.f
hdl/bp_pkg.sv
hdl/branch_predict.sv
hdl/branch_decode.sv
hdl/branch_execute.sv
hdl/branch_result.sv
hdl/branch_unit_top.sv
tests/tb_branch_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the branch unit testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_branch_unit \
        -f branch_unit_top.f -o sim_branch_unit

./obj_dir/sim_branch_unit > sim.log 2>&1
cat sim.log

if grep -q "Done: errors found" sim.log
then
        echo "Simulation failed, see sim.log"
        exit 1
fi
if ! grep -q "Done: no errors" sim.log
then
        echo "Simulation ended without a result line"
        exit 1
fi
echo "Simulation passed"
